//--- sources.f
calc_pkg.sv
alu_ctrl_if.sv
key_conditioner.sv
alu.sv
reg_alu.sv
rpn_control.sv
rpn_calculator_top.sv
tb_rpn_calculator_sva.sv
tb_rpn_calculator.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the rpn calculator testbench with verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rpn_calculator -f sources.f
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_rpn_calculator 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "simulation returned status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "all tests passed"; then
    exit 0
fi

echo "pass line not found in simulation output"
exit 1

//--- tb_rpn_calculator.sv
`timescale 1ns/1ps

module tb_rpn_calculator
    import calc_pkg::*;
();

    localparam int WIDTH = 16;
    localparam int PERIOD = 40;
    localparam int SEED = 79014;
    localparam int NUM_ROWS = 14;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 12 * 8 + 200;

    // what a row does besides the plain a, b, opcode sequence.
    localparam logic [2:0] ACT_NONE    = 3'd0;
    localparam logic [2:0] ACT_UNDO_A  = 3'd1; // undo in wait_b, new a.
    localparam logic [2:0] ACT_UNDO_B  = 3'd2; // undo in wait_op, new b.
    localparam logic [2:0] ACT_UNDO_OP = 3'd3; // undo in show_res, new opcode.
    localparam logic [2:0] ACT_BOTH    = 3'd4; // enter and undo together for b.

    typedef struct packed {
        logic             rnd;
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        opcode_t          op;
        logic [2:0]       action;
        logic [WIDTH-1:0] repl;
        logic [WIDTH-1:0] res;
        alu_flags_t       flags;
    } row_t;

    // rnd, a, b, op, action, replacement, result, flags (ovf carry neg zero).
    localparam row_t ROWS [NUM_ROWS] = '{
        '{1'b0, 16'hFFFF, 16'h0002, OP_ADD, ACT_NONE,    16'h0000, 16'h0001, 4'b0100},
        '{1'b0, 16'h7FFF, 16'h0001, OP_ADD, ACT_NONE,    16'h0000, 16'h8000, 4'b1010},
        '{1'b0, 16'h0003, 16'h0005, OP_SUB, ACT_NONE,    16'h0000, 16'hFFFE, 4'b0110},
        '{1'b0, 16'h1234, 16'h1234, OP_SUB, ACT_NONE,    16'h0000, 16'h0000, 4'b0001},
        '{1'b0, 16'hF0F0, 16'h3C3C, OP_AND, ACT_NONE,    16'h0000, 16'h3030, 4'b0000},
        '{1'b0, 16'h8001, 16'h0100, OP_OR,  ACT_NONE,    16'h0000, 16'h8101, 4'b0010},
        '{1'b0, 16'h1111, 16'h0003, OP_SUB, ACT_UNDO_A,  16'h0005, 16'h0002, 4'b0000},
        '{1'b0, 16'h4000, 16'h0001, OP_ADD, ACT_UNDO_B,  16'h4000, 16'h8000, 4'b1010},
        '{1'b0, 16'h00FF, 16'h0F0F, OP_ADD, ACT_UNDO_OP, 16'h0002, 16'h000F, 4'b0000},
        '{1'b0, 16'h0010, 16'h0020, OP_OR,  ACT_BOTH,    16'h0000, 16'h0030, 4'b0000},
        '{1'b1, 16'h0000, 16'h0000, OP_ADD, ACT_NONE,    16'h0000, 16'h0000, 4'b0000},
        '{1'b1, 16'h0000, 16'h0000, OP_SUB, ACT_NONE,    16'h0000, 16'h0000, 4'b0000},
        '{1'b1, 16'h0000, 16'h0000, OP_AND, ACT_NONE,    16'h0000, 16'h0000, 4'b0000},
        '{1'b1, 16'h0000, 16'h0000, OP_OR,  ACT_NONE,    16'h0000, 16'h0000, 4'b0000}
    };

    logic             clk = 1'b0;
    logic             reset;
    logic             i_enter;
    logic             i_undo;
    logic [WIDTH-1:0] i_data;
    logic [WIDTH-1:0] o_data;
    logic [7:0]       o_current_state;
    logic             o_display_sel;
    alu_flags_t       o_flags;

    logic [15:0]      lfsr_q;
    logic [WIDTH-1:0] prev_result;
    calc_state_t      waiting_for;

    always #(PERIOD / 2) clk = ~clk;

    rpn_calculator_top #(
        .WIDTH (WIDTH)
    ) u_dut (
        .clk             (clk),
        .reset           (reset),
        .i_enter         (i_enter),
        .i_undo          (i_undo),
        .i_data          (i_data),
        .o_data          (o_data),
        .o_current_state (o_current_state),
        .o_display_sel   (o_display_sel),
        .o_flags         (o_flags)
    );

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_word(output logic [WIDTH-1:0] w);
        for (int i = 0; i < WIDTH; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            w[i] = lfsr_q[0];
        end
    endtask

    // reference result, packed as {flags, result}.
    function automatic logic [WIDTH+3:0] model(input logic [WIDTH-1:0] a,
                                               input logic [WIDTH-1:0] b, input opcode_t op);
        logic [WIDTH-1:0] res;
        alu_flags_t       fl;
        int               wide_s;
        fl = '0;
        wide_s = 0;
        case (op)
            OP_ADD: begin
                res = a + b;
                fl[FLAG_CARRY] = (int'(a) + int'(b)) > (2 ** WIDTH - 1);
                wide_s = int'($signed(a)) + int'($signed(b));
            end
            OP_SUB: begin
                res = a - b;
                fl[FLAG_CARRY] = a < b; // borrow.
                wide_s = int'($signed(a)) - int'($signed(b));
            end
            OP_AND:  res = a & b;
            default: res = a | b;
        endcase
        fl[FLAG_OVF]  = (wide_s > 2 ** (WIDTH - 1) - 1) || (wide_s < -(2 ** (WIDTH - 1)));
        fl[FLAG_ZERO] = res == '0;
        fl[FLAG_NEG]  = res[WIDTH-1];
        return {fl, res};
    endfunction

    function automatic logic [WIDTH-1:0] op_word(input opcode_t op);
        return {{(WIDTH - 2){1'b0}}, op};
    endfunction

    // hold the keys, release, then wait for the controller to settle in target.
    task automatic press(input logic enter, input logic undo, input logic [WIDTH-1:0] data,
                         input int hold, input calc_state_t target);
        waiting_for = target;
        @(negedge clk);
        i_data  = data;
        i_enter = enter;
        i_undo  = undo;
        repeat (hold) @(negedge clk);
        i_enter = 1'b0;
        i_undo  = 1'b0;
        repeat (2) @(negedge clk);
        while (o_current_state !== target) @(negedge clk);
    endtask

    task automatic run_row(input int idx);
        row_t             row;
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        opcode_t          op;
        logic [WIDTH+3:0] expected;
        row = ROWS[idx];
        a = row.a;
        b = row.b;
        op = row.op;
        if (row.rnd) begin
            random_word(a);
            random_word(b);
        end
        press(1'b1, 1'b0, a, 3, S_WAIT_B);
        if (row.action == ACT_UNDO_A) begin
            press(1'b0, 1'b1, row.repl, 3, S_WAIT_A);
            press(1'b1, 1'b0, row.repl, 3, S_WAIT_B);
            a = row.repl;
        end
        press(1'b1, row.action == ACT_BOTH, b, 3, S_WAIT_OP);
        check_value("o_data", 32'(o_data), 32'(prev_result)); // old result still shown.
        if (row.action == ACT_UNDO_B) begin
            press(1'b0, 1'b1, row.repl, 3, S_WAIT_B);
            press(1'b1, 1'b0, row.repl, 3, S_WAIT_OP);
            b = row.repl;
        end
        press(1'b1, 1'b0, op_word(op), 3, S_SHOW_RES);
        if (row.action == ACT_UNDO_OP) begin
            op = row.repl[1:0];
            press(1'b0, 1'b1, op_word(op), 3, S_WAIT_OP);
            press(1'b1, 1'b0, op_word(op), 3, S_SHOW_RES);
        end
        if (row.rnd) expected = model(a, b, op);
        else expected = {row.flags, row.res};
        check_value("o_display_sel", 32'(o_display_sel), 32'd1);
        check_value("o_data", 32'(o_data), 32'(expected[WIDTH-1:0]));
        check_value("o_flags", 32'(o_flags), 32'(expected[WIDTH+3:WIDTH]));
        press(1'b1, 1'b0, op_word(op), 3, S_WAIT_A);
        check_value("o_display_sel", 32'(o_display_sel), 32'd0);
        check_value("o_data", 32'(o_data), 32'(expected[WIDTH-1:0]));
        prev_result = expected[WIDTH-1:0];
    endtask

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout at %0t ns: state %s never reached, o_current_state is %b",
                 $time, waiting_for.name(), o_current_state);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        reset = 1'b1;
        i_enter = 1'b0;
        i_undo = 1'b0;
        i_data = '0;
        lfsr_q = SEED[15:0];
        prev_result = '0;
        waiting_for = S_WAIT_A;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value("o_current_state", 32'(o_current_state), 32'(S_WAIT_A));
        check_value("o_display_sel", 32'(o_display_sel), 32'd0);
        check_value("o_data", 32'(o_data), 32'd0);
        check_value("o_flags", 32'(o_flags), 32'd0);

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end

        // a long press still advances only one stage.
        press(1'b1, 1'b0, 16'h00AA, 20, S_WAIT_B);
        repeat (3) @(negedge clk);
        check_value("o_current_state", 32'(o_current_state), 32'(S_WAIT_B));
        press(1'b0, 1'b1, 16'h00AA, 3, S_WAIT_A);
        press(1'b0, 1'b1, 16'h00AA, 3, S_WAIT_A);
        repeat (3) @(negedge clk);
        check_value("o_current_state", 32'(o_current_state), 32'(S_WAIT_A));

        $display("all tests passed");
        $finish;
    end

endmodule

//--- tb_rpn_calculator_sva.sv
`timescale 1ns/1ps

module rpn_control_sva
    import calc_pkg::*;
(
    input logic        i_clk,
    input logic        i_reset,
    input logic        i_enter,
    input logic        i_undo,
    input calc_state_t state,
    input logic        load_a,
    input logic        load_b,
    input logic        load_op,
    input logic        update_res,
    input logic        display_sel
);

    logic [3:0] strobes;

    assign strobes = {update_res, load_op, load_b, load_a};

    a_one_hot: assert property (@(posedge i_clk) disable iff (i_reset) $onehot(state))
        else $error("controller state is not one-hot");

    a_strobe_excl: assert property (@(posedge i_clk) disable iff (i_reset) $onehot0(strobes))
        else $error("more than one load strobe is high");

    // no strobe may stay high into the next cycle.
    a_strobe_len: assert property (@(posedge i_clk) disable iff (i_reset)
        (|strobes) |=> ((strobes & $past(strobes)) == 4'b0000))
        else $error("a load strobe lasted more than one cycle");

    a_display: assert property (@(posedge i_clk) disable iff (i_reset)
        display_sel == (state == S_SHOW_RES))
        else $error("display select does not match the show state");

    a_undo_idle: assert property (@(posedge i_clk) disable iff (i_reset)
        (state == S_WAIT_A && i_undo && !i_enter) |=> (state == S_WAIT_A))
        else $error("undo moved the controller out of the first wait state");

endmodule

bind rpn_control rpn_control_sva u_sva (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_enter     (i_enter),
    .i_undo      (i_undo),
    .state       (o_state),
    .load_a      (ctrl.load_a),
    .load_b      (ctrl.load_b),
    .load_op     (ctrl.load_op),
    .update_res  (ctrl.update_res),
    .display_sel (o_display_sel)
);

//--- rpn_calculator_top.sv
`timescale 1ns/1ps

module rpn_calculator_top
    import calc_pkg::*;
#(
    parameter int WIDTH = 16
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           i_enter,
    input  logic                           i_undo,
    input  logic [WIDTH-1:0]               i_data,
    output logic [WIDTH-1:0]               o_data,
    output logic [$bits(calc_state_t)-1:0] o_current_state,
    output logic                           o_display_sel,
    output alu_flags_t                     o_flags
);

    logic enter_pulse;
    logic undo_pulse;

    alu_ctrl_if ctrl_if ();

    key_conditioner u_keys (
        .i_clk         (clk),
        .i_reset       (reset),
        .i_enter       (i_enter),
        .i_undo        (i_undo),
        .o_enter_pulse (enter_pulse),
        .o_undo_pulse  (undo_pulse)
    );

    rpn_control u_control (
        .i_clk         (clk),
        .i_reset       (reset),
        .i_enter       (enter_pulse),
        .i_undo        (undo_pulse),
        .ctrl          (ctrl_if.controller),
        .o_state       (o_current_state),
        .o_display_sel (o_display_sel)
    );

    reg_alu #(
        .WIDTH (WIDTH)
    ) u_datapath (
        .i_clk    (clk),
        .i_reset  (reset),
        .i_data   (i_data),
        .ctrl     (ctrl_if.datapath),
        .o_result (o_data),
        .o_flags  (o_flags)
    );

endmodule

//--- rpn_control.sv
`timescale 1ns/1ps

module rpn_control
    import calc_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_reset,
    input  logic            i_enter,
    input  logic            i_undo,
    alu_ctrl_if.controller  ctrl,
    output calc_state_t     o_state,
    output logic            o_display_sel
);

    calc_state_t state_q;
    calc_state_t state_d;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q <= S_WAIT_A;
        end else begin
            state_q <= state_d;
        end
    end

    // enter has priority over undo in every wait state.
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_WAIT_A: begin
                if (i_enter) state_d = S_LOAD_A; // undo has nowhere to go.
            end
            S_LOAD_A: begin
                state_d = S_WAIT_B;
            end
            S_WAIT_B: begin
                if (i_enter) begin
                    state_d = S_LOAD_B;
                end else if (i_undo) begin
                    state_d = S_WAIT_A;
                end
            end
            S_LOAD_B: begin
                state_d = S_WAIT_OP;
            end
            S_WAIT_OP: begin
                if (i_enter) begin
                    state_d = S_LOAD_OP;
                end else if (i_undo) begin
                    state_d = S_WAIT_B;
                end
            end
            S_LOAD_OP: begin
                state_d = S_LOAD_RES;
            end
            S_LOAD_RES: begin
                state_d = S_SHOW_RES;
            end
            S_SHOW_RES: begin
                if (i_enter) begin
                    state_d = S_WAIT_A;
                end else if (i_undo) begin
                    state_d = S_WAIT_OP; // pick another opcode.
                end
            end
            default: begin
                state_d = S_WAIT_A;
            end
        endcase
    end

    // moore outputs.
    always_comb begin
        ctrl.load_a     = 1'b0;
        ctrl.load_b     = 1'b0;
        ctrl.load_op    = 1'b0;
        ctrl.update_res = 1'b0;
        o_display_sel   = 1'b0;
        case (state_q)
            S_LOAD_A:   ctrl.load_a     = 1'b1;
            S_LOAD_B:   ctrl.load_b     = 1'b1;
            S_LOAD_OP:  ctrl.load_op    = 1'b1;
            S_LOAD_RES: ctrl.update_res = 1'b1;
            S_SHOW_RES: o_display_sel   = 1'b1;
            default: begin
                o_display_sel = 1'b0;
            end
        endcase
    end

    assign o_state = state_q;

endmodule

//--- reg_alu.sv
`timescale 1ns/1ps

module reg_alu
    import calc_pkg::*;
#(
    parameter int WIDTH = 16
) (
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic [WIDTH-1:0]  i_data,
    alu_ctrl_if.datapath      ctrl,
    output logic [WIDTH-1:0]  o_result,
    output alu_flags_t        o_flags
);

    logic [WIDTH-1:0] a_q;
    logic [WIDTH-1:0] b_q;
    opcode_t          op_q;
    logic [WIDTH-1:0] result_q;
    alu_flags_t       flags_q;

    logic [WIDTH-1:0] alu_result;
    alu_flags_t       alu_flags;

    alu #(
        .WIDTH (WIDTH)
    ) u_alu (
        .i_a      (a_q),
        .i_b      (b_q),
        .i_op     (op_q),
        .o_result (alu_result),
        .o_flags  (alu_flags)
    );

    // operands and opcode share the one data input.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            a_q  <= '0;
            b_q  <= '0;
            op_q <= '0;
        end else begin
            if (ctrl.load_a)  a_q  <= i_data;
            if (ctrl.load_b)  b_q  <= i_data;
            if (ctrl.load_op) op_q <= i_data[1:0];
        end
    end

    // result is held until the next update.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            result_q <= '0;
            flags_q  <= '0;
        end else if (ctrl.update_res) begin
            result_q <= alu_result;
            flags_q  <= alu_flags;
        end
    end

    assign o_result = result_q;
    assign o_flags  = flags_q;

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu
    import calc_pkg::*;
#(
    parameter int WIDTH = 16
) (
    input  logic [WIDTH-1:0] i_a,
    input  logic [WIDTH-1:0] i_b,
    input  opcode_t          i_op,
    output logic [WIDTH-1:0] o_result,
    output alu_flags_t       o_flags
);

    logic [WIDTH:0] sum;
    logic [WIDTH:0] diff;
    logic           sign_a;
    logic           sign_b;

    assign sum  = {1'b0, i_a} + {1'b0, i_b};
    assign diff = {1'b0, i_a} - {1'b0, i_b}; // top bit is the borrow.

    assign sign_a = i_a[WIDTH-1];
    assign sign_b = i_b[WIDTH-1];

    always_comb begin
        o_result              = '0;
        o_flags               = '0;
        case (i_op)
            OP_ADD: begin
                o_result              = sum[WIDTH-1:0];
                o_flags[FLAG_CARRY]   = sum[WIDTH];
                o_flags[FLAG_OVF]     = (sign_a == sign_b) && (sum[WIDTH-1] != sign_a);
            end
            OP_SUB: begin
                o_result              = diff[WIDTH-1:0];
                o_flags[FLAG_CARRY]   = diff[WIDTH];
                o_flags[FLAG_OVF]     = (sign_a != sign_b) && (diff[WIDTH-1] != sign_a);
            end
            OP_AND: begin
                o_result              = i_a & i_b;
            end
            OP_OR: begin
                o_result              = i_a | i_b;
            end
        endcase
        o_flags[FLAG_ZERO] = (o_result == '0);
        o_flags[FLAG_NEG]  = o_result[WIDTH-1];
    end

endmodule

//--- key_conditioner.sv
`timescale 1ns/1ps

module key_conditioner (
    input  logic i_clk,
    input  logic i_reset,
    input  logic i_enter,
    input  logic i_undo,
    output logic o_enter_pulse,
    output logic o_undo_pulse
);

    // bit 0 is enter, bit 1 is undo.
    logic [1:0] sync_q1;
    logic [1:0] sync_q2;
    logic [1:0] prev_q;
    logic [1:0] pulse_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            sync_q1 <= 2'b00;
            sync_q2 <= 2'b00;
            prev_q  <= 2'b00;
            pulse_q <= 2'b00;
        end else begin
            sync_q1 <= {i_undo, i_enter};
            sync_q2 <= sync_q1;
            prev_q  <= sync_q2;
            pulse_q <= sync_q2 & ~prev_q; // rising edge only.
        end
    end

    assign o_enter_pulse = pulse_q[0];
    assign o_undo_pulse  = pulse_q[1];

endmodule

//--- alu_ctrl_if.sv
`timescale 1ns/1ps

interface alu_ctrl_if;

    logic load_a;     // capture operand a.
    logic load_b;     // capture operand b.
    logic load_op;    // capture opcode.
    logic update_res; // capture alu result and flags.

    modport controller (
        output load_a,
        output load_b,
        output load_op,
        output update_res
    );

    modport datapath (
        input load_a,
        input load_b,
        input load_op,
        input update_res
    );

endinterface

//--- calc_pkg.sv
package calc_pkg;

    typedef logic [1:0] opcode_t;
    typedef logic [3:0] alu_flags_t;

    localparam opcode_t OP_ADD = 2'd0;
    localparam opcode_t OP_SUB = 2'd1;
    localparam opcode_t OP_AND = 2'd2;
    localparam opcode_t OP_OR  = 2'd3;

    // bit positions inside alu_flags_t.
    localparam int FLAG_ZERO  = 0;
    localparam int FLAG_NEG   = 1;
    localparam int FLAG_CARRY = 2;
    localparam int FLAG_OVF   = 3;

    // one-hot entry sequence, bit 0 first.
    typedef enum logic [7:0] {
        S_WAIT_A   = 8'b0000_0001,
        S_LOAD_A   = 8'b0000_0010,
        S_WAIT_B   = 8'b0000_0100,
        S_LOAD_B   = 8'b0000_1000,
        S_WAIT_OP  = 8'b0001_0000,
        S_LOAD_OP  = 8'b0010_0000,
        S_LOAD_RES = 8'b0100_0000,
        S_SHOW_RES = 8'b1000_0000
    } calc_state_t;

endpackage
